// ==== logic/core_if_pkg.sv ====
// Core-side interface types
package core_if_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Width of the scoreboard transaction ID
  localparam int unsigned TRANS_ID_BITS = 3;

  // Exception cause for an instruction the accelerator rejects
  localparam logic [4:0] CAUSE_ILLEGAL_INSTR = 5'd2;

  // Operator class of an accelerator instruction
  // Load and store only matter for the dispatch flags
  typedef enum logic [1:0] {
    ACC_OP_ARITH = 2'd0,
    ACC_OP_LOAD  = 2'd1,
    ACC_OP_STORE = 2'd2
  } fu_op_e;

  // Issued instruction as seen by a functional unit
  typedef struct packed {
    fu_op_e                   operator;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    // Decoder forwards the raw instruction word here
    logic [XLEN-1:0]          imm;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

  // Exception record handed back with a result
  typedef struct packed {
    logic [4:0]      cause;
    logic [XLEN-1:0] tval;
    logic            valid;
  } exception_t;

endpackage

// ==== logic/acc_if_pkg.sv ====
// Accelerator request and response types
package acc_if_pkg;

  // Cycles from accepting handshake to response
  localparam int unsigned ACC_LATENCY = 2;

  // Function select from instruction bits 14 to 12
  // Codes 5 to 7 are not assigned and raise an error
  typedef enum logic [2:0] {
    ACC_ADD   = 3'd0,
    ACC_SUB   = 3'd1,
    ACC_XOR   = 3'd2,
    ACC_MULLO = 3'd3,
    ACC_MAX   = 3'd4
  } acc_func_e;

  // Request toward the accelerator
  typedef struct packed {
    logic [31:0]                           insn;
    logic [core_if_pkg::XLEN-1:0]          rs1;
    logic [core_if_pkg::XLEN-1:0]          rs2;
    logic [core_if_pkg::TRANS_ID_BITS-1:0] trans_id;
    // Live view of the load/store unit, not part of the instruction
    logic                                  store_pending;
  } acc_req_t;

  // Response from the accelerator
  typedef struct packed {
    logic [core_if_pkg::XLEN-1:0]          result;
    logic [core_if_pkg::TRANS_ID_BITS-1:0] trans_id;
    logic                                  error;
  } acc_resp_t;

endpackage

// ==== logic/acc_issue_buffer.sv ====
// Two-entry issue buffer
module acc_issue_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Upstream from the issue stage
  input  core_if_pkg::fu_data_t data_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  // Downstream toward the dispatcher
  output core_if_pkg::fu_data_t data_o,
  output logic                  valid_o,
  input  logic                  ready_i
);
  import core_if_pkg::*;

  // Head slot drives the output, spare slot catches overflow
  fu_data_t head_q;
  fu_data_t spare_q;
  logic     head_valid_q;
  logic     spare_valid_q;
  logic     push;
  logic     pop;

  // Ready only depends on the spare slot, so it comes from a flop
  assign ready_o = !spare_valid_q;
  assign valid_o = head_valid_q;
  assign data_o  = head_q;

  assign push = valid_i && ready_o;
  assign pop  = head_valid_q && ready_i;

  // Occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (flush_i) begin
      // Drop everything still waiting
      head_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (spare_valid_q) begin
      // Full, so no push this cycle
      // Head refills from the spare on a pop and stays valid
      if (pop) begin
        spare_valid_q <= 1'b0;
      end
    end else begin
      head_valid_q <= push || (head_valid_q && !pop);
      // Second entry only when the head cannot leave
      if (push && head_valid_q && !pop) begin
        spare_valid_q <= 1'b1;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (spare_valid_q) begin
      if (pop) begin
        head_q <= spare_q;
      end
    end else if (push && (!head_valid_q || pop)) begin
      // Empty or draining head takes the new entry directly
      head_q <= data_i;
    end
    if (push && head_valid_q && !pop) begin
      spare_q <= data_i;
    end
  end

  // Issue stage must hold off while full, otherwise an instruction is lost
  issue_not_lost_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    valid_i |-> ready_o
  ) else $error("acc_issue_buffer: instruction issued while buffer full");

endmodule

// ==== logic/acc_dispatcher.sv ====
// Commit-gated accelerator dispatcher
module acc_dispatcher (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  // Head instruction from the issue buffer
  input  core_if_pkg::fu_data_t                 buf_data_i,
  input  logic                                  buf_valid_i,
  output logic                                  buf_ready_o,
  // Commit stage
  input  logic                                  commit_i,
  input  logic [core_if_pkg::TRANS_ID_BITS-1:0] commit_trans_id_i,
  // Load/store unit
  input  logic                                  no_st_pending_i,
  // Accelerator request
  output acc_if_pkg::acc_req_t                  req_o,
  output logic                                  req_valid_o,
  input  logic                                  req_ready_i,
  // Accelerator response, always accepted
  input  acc_if_pkg::acc_resp_t                 resp_i,
  input  logic                                  resp_valid_i,
  // Toward the issue stage and writeback
  output logic                                  ld_disp_o,
  output logic                                  st_disp_o,
  output logic                                  result_valid_o,
  output logic [core_if_pkg::TRANS_ID_BITS-1:0] trans_id_o,
  output logic [core_if_pkg::XLEN-1:0]          result_o,
  output core_if_pkg::exception_t               exception_o
);
  import core_if_pkg::*;

  logic match_q;
  logic match_now;
  logic match;
  logic req_hs;

  // Commit for the current head, only while the head is real
  // Stale data after a pop or flush must not match
  assign match_now = buf_valid_i && commit_i && (commit_trans_id_i == buf_data_i.trans_id);

  // Registered match or one arriving right now
  assign match = match_q || match_now;

  // Speculative head waits here until committed
  assign req_valid_o = buf_valid_i && match;
  assign req_hs      = req_valid_o && req_ready_i;
  assign buf_ready_o = req_ready_i && match;

  // Sticky match, cleared once the request is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      match_q <= 1'b0;
    end else if (flush_i) begin
      match_q <= 1'b0;
    end else if (req_hs) begin
      match_q <= 1'b0;
    end else if (match_now) begin
      match_q <= 1'b1;
    end
  end

  // Unpack issued data into an accelerator request
  // Instruction word arrives through the immediate field
  assign req_o = '{
    insn:          buf_data_i.imm[31:0],
    rs1:           buf_data_i.operand_a,
    rs2:           buf_data_i.operand_b,
    trans_id:      buf_data_i.trans_id,
    store_pending: !no_st_pending_i
  };

  // Dispatch flags toward the issue stage, one pulse per request
  assign ld_disp_o = req_hs && (buf_data_i.operator == ACC_OP_LOAD);
  assign st_disp_o = req_hs && (buf_data_i.operator == ACC_OP_STORE);

  // Response unpacking
  assign result_valid_o = resp_valid_i;
  assign trans_id_o     = resp_i.trans_id;
  assign result_o       = resp_i.result;
  // Accelerator error maps to an illegal instruction
  assign exception_o = '{
    cause: CAUSE_ILLEGAL_INSTR,
    tval:  '0,
    valid: resp_i.error
  };

  // Waiting request keeps its instruction fields
  // store_pending follows the load/store unit and may change
  req_stable_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (req_valid_o && !req_ready_i && !flush_i) |=>
      (req_valid_o && $stable({req_o.insn, req_o.rs1, req_o.rs2, req_o.trans_id}))
  ) else $error("acc_dispatcher: request changed while waiting for ready");

endmodule

// ==== logic/acc_unit.sv ====
// Pipelined accelerator unit
module acc_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request
  input  acc_if_pkg::acc_req_t  req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Response, fixed latency
  output acc_if_pkg::acc_resp_t resp_o,
  output logic                  resp_valid_o
);
  import core_if_pkg::*;
  import acc_if_pkg::*;

  logic                     req_hs;
  acc_func_e                dec_func;
  logic                     dec_illegal;

  // Stage one registers
  logic                     s1_valid_q;
  acc_func_e                s1_func_q;
  logic                     s1_illegal_q;
  logic [XLEN-1:0]          s1_rs1_q;
  logic [XLEN-1:0]          s1_rs2_q;
  logic [TRANS_ID_BITS-1:0] s1_trans_id_q;

  // Stage two
  logic [XLEN-1:0]          s2_result;
  logic                     s2_valid_q;
  acc_resp_t                s2_resp_q;

  // A pending store blocks new work
  assign req_ready_o = !req_i.store_pending;
  assign req_hs      = req_valid_i && req_ready_o;

  // Function decode from funct3
  always_comb begin
    dec_func    = ACC_ADD;
    dec_illegal = 1'b0;
    case (req_i.insn[14:12])
      ACC_ADD, ACC_SUB, ACC_XOR, ACC_MULLO, ACC_MAX: begin
        dec_func = acc_func_e'(req_i.insn[14:12]);
      end
      default: begin
        dec_illegal = 1'b1;
      end
    endcase
  end

  // Execute on stage one operands
  always_comb begin
    case (s1_func_q)
      ACC_ADD:   s2_result = s1_rs1_q + s1_rs2_q;
      ACC_SUB:   s2_result = s1_rs1_q - s1_rs2_q;
      ACC_XOR:   s2_result = s1_rs1_q ^ s1_rs2_q;
      // Low half of the product
      ACC_MULLO: s2_result = s1_rs1_q * s1_rs2_q;
      ACC_MAX: begin
        s2_result = ($signed(s1_rs1_q) > $signed(s1_rs2_q)) ? s1_rs1_q : s1_rs2_q;
      end
      default:   s2_result = '0;
    endcase
    // Illegal codes return zero
    if (s1_illegal_q) begin
      s2_result = '0;
    end
  end

  // Pipeline valids
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_hs;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Pipeline payload
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      s1_func_q     <= dec_func;
      s1_illegal_q  <= dec_illegal;
      s1_rs1_q      <= req_i.rs1;
      s1_rs2_q      <= req_i.rs2;
      s1_trans_id_q <= req_i.trans_id;
    end
    if (s1_valid_q) begin
      s2_resp_q <= '{result: s2_result, trans_id: s1_trans_id_q, error: s1_illegal_q};
    end
  end

  assign resp_o       = s2_resp_q;
  assign resp_valid_o = s2_valid_q;

  // Every response traces back to its own handshake ACC_LATENCY cycles earlier
  // Error flag set only for the unassigned funct3 codes 5 to 7
  resp_latency_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    resp_valid_o |-> ($past(req_hs, ACC_LATENCY) &&
                      (resp_o.trans_id == $past(req_i.trans_id, ACC_LATENCY)) &&
                      (resp_o.error == ($past(req_i.insn[14:12], ACC_LATENCY) > 3'd4)))
  ) else $error("acc_unit: response does not match the request taken earlier");

endmodule

// ==== logic/acc_offload_top.sv ====
// Accelerator offload top level
module acc_offload_top (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  // Issue stage
  input  core_if_pkg::fu_data_t                 acc_data_i,
  input  logic                                  acc_valid_i,
  output logic                                  acc_ready_o,
  // Commit stage
  input  logic                                  acc_commit_i,
  input  logic [core_if_pkg::TRANS_ID_BITS-1:0] acc_commit_trans_id_i,
  // Load/store side
  input  logic                                  acc_no_st_pending_i,
  output logic                                  acc_ld_disp_o,
  output logic                                  acc_st_disp_o,
  // Writeback
  output logic                                  acc_result_valid_o,
  output logic [core_if_pkg::TRANS_ID_BITS-1:0] acc_trans_id_o,
  output logic [core_if_pkg::XLEN-1:0]          acc_result_o,
  output core_if_pkg::exception_t               acc_exception_o
);
  import core_if_pkg::*;
  import acc_if_pkg::*;

  // Buffer to dispatcher
  fu_data_t  buf_data;
  logic      buf_valid;
  logic      buf_ready;

  // Dispatcher and accelerator
  acc_req_t  acc_req;
  logic      acc_req_valid;
  logic      acc_req_ready;
  acc_resp_t acc_resp;
  logic      acc_resp_valid;

  acc_issue_buffer issue_buffer_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .data_i  (acc_data_i),
    .valid_i (acc_valid_i),
    .ready_o (acc_ready_o),
    .data_o  (buf_data),
    .valid_o (buf_valid),
    .ready_i (buf_ready)
  );

  acc_dispatcher dispatcher_inst (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .buf_data_i        (buf_data),
    .buf_valid_i       (buf_valid),
    .buf_ready_o       (buf_ready),
    .commit_i          (acc_commit_i),
    .commit_trans_id_i (acc_commit_trans_id_i),
    .no_st_pending_i   (acc_no_st_pending_i),
    .req_o             (acc_req),
    .req_valid_o       (acc_req_valid),
    .req_ready_i       (acc_req_ready),
    .resp_i            (acc_resp),
    .resp_valid_i      (acc_resp_valid),
    .ld_disp_o         (acc_ld_disp_o),
    .st_disp_o         (acc_st_disp_o),
    .result_valid_o    (acc_result_valid_o),
    .trans_id_o        (acc_trans_id_o),
    .result_o          (acc_result_o),
    .exception_o       (acc_exception_o)
  );

  acc_unit unit_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (acc_req),
    .req_valid_i  (acc_req_valid),
    .req_ready_o  (acc_req_ready),
    .resp_o       (acc_resp),
    .resp_valid_o (acc_resp_valid)
  );

endmodule

// ==== bench/acc_offload_checker.sv ====
// Offload result checker
module acc_offload_checker (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  result_valid_i,
  input  logic [core_if_pkg::TRANS_ID_BITS-1:0] trans_id_i,
  input  logic [core_if_pkg::XLEN-1:0]          result_i,
  input  core_if_pkg::exception_t               exception_i,
  input  logic                                  ld_disp_i,
  input  logic                                  st_disp_i
);
  import core_if_pkg::*;

  // One expected response, in commit order
  typedef struct packed {
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
    logic                     error;
  } expect_t;

  expect_t     expected_q[$];
  int unsigned error_count  = 0;
  int unsigned results_seen = 0;
  int unsigned test_errors  = 0;
  int unsigned tests_run    = 0;
  int unsigned ld_seen      = 0;
  int unsigned st_seen      = 0;
  int unsigned ld_expected  = 0;
  int unsigned st_expected  = 0;

  function automatic int unsigned pending();
    return expected_q.size();
  endfunction

  task automatic add_expected(logic [TRANS_ID_BITS-1:0] id, logic [XLEN-1:0] result,
                              logic error, fu_op_e op);
    expected_q.push_back('{trans_id: id, result: result, error: error});
    if (op == ACC_OP_LOAD) ld_expected++;
    if (op == ACC_OP_STORE) st_expected++;
  endtask

  // Failures other than a wrong value
  task automatic note_error(string what);
    $display("Error at %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic mismatch(string what);
    $display("Fail at %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic start_test();
    test_errors = error_count;
  endtask

  task automatic end_test(string name);
    if (ld_seen != ld_expected || st_seen != st_expected) begin
      mismatch($sformatf("dispatch flags ld %0d st %0d, expected ld %0d st %0d",
                         ld_seen, st_seen, ld_expected, st_expected));
    end
    tests_run++;
    $display("Test %s finished with %0d errors", name, error_count - test_errors);
  endtask

  task automatic print_summary();
    $display("Tests %0d, results checked %0d, errors %0d", tests_run, results_seen,
             error_count);
  endtask

  // Dispatch flag pulses
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (ld_disp_i) ld_seen++;
      if (st_disp_i) st_seen++;
      if (ld_disp_i && st_disp_i) note_error("load and store flags raised together");
    end
  end

  // Responses must follow commit order
  always @(posedge clk_i) begin
    expect_t exp;
    if (!rst_i && result_valid_i) begin
      results_seen++;
      if (expected_q.size() == 0) begin
        note_error($sformatf("unexpected result for trans_id %0d", trans_id_i));
      end else begin
        exp = expected_q.pop_front();
        if (trans_id_i != exp.trans_id) begin
          mismatch($sformatf("trans_id %0d, expected %0d", trans_id_i, exp.trans_id));
        end
        if (result_i != exp.result) begin
          mismatch($sformatf("result %08h, expected %08h", result_i, exp.result));
        end
        if (exception_i.valid != exp.error) begin
          mismatch($sformatf("exception valid %0b, expected %0b", exception_i.valid,
                             exp.error));
        end else if (exp.error && (exception_i.cause != 5'd2 || exception_i.tval != '0)) begin
          mismatch($sformatf("exception cause %0d tval %08h, expected 2 and 0",
                             exception_i.cause, exception_i.tval));
        end
      end
    end
  end

endmodule

// ==== bench/acc_offload_tb.sv ====
// Offload path testbench
module acc_offload_tb;
  import core_if_pkg::*;

  // Total instructions issued by all tests, sizes the watchdog
  localparam int unsigned NUM_INSNS = 31;

  logic                     clk_i;
  logic                     rst_i;
  logic                     flush_i;
  fu_data_t                 acc_data_i;
  logic                     acc_valid_i;
  logic                     acc_ready_o;
  logic                     acc_commit_i;
  logic [TRANS_ID_BITS-1:0] acc_commit_trans_id_i;
  logic                     acc_no_st_pending_i;
  logic                     acc_ld_disp_o;
  logic                     acc_st_disp_o;
  logic                     acc_result_valid_o;
  logic [TRANS_ID_BITS-1:0] acc_trans_id_o;
  logic [XLEN-1:0]          acc_result_o;
  exception_t               acc_exception_o;

  logic [31:0]              lfsr_q = 32'hb1b855da;
  logic [TRANS_ID_BITS-1:0] next_id;
  int unsigned              seen_before;

  acc_offload_top acc_offload_top_inst (.*);

  acc_offload_checker checker_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .result_valid_i (acc_result_valid_o),
    .trans_id_i     (acc_trans_id_o),
    .result_i       (acc_result_o),
    .exception_i    (acc_exception_o),
    .ld_disp_i      (acc_ld_disp_o),
    .st_disp_i      (acc_st_disp_o)
  );

  always #5 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Expected {error, result} of one accelerator function
  function automatic logic [32:0] ref_exec(logic [2:0] func, logic [31:0] a, logic [31:0] b);
    logic [63:0] prod;
    prod = a * b;
    case (func)
      3'd0:    return {1'b0, a + b};
      3'd1:    return {1'b0, a - b};
      3'd2:    return {1'b0, a ^ b};
      3'd3:    return {1'b0, prod[31:0]};
      3'd4:    return {1'b0, ($signed(a) > $signed(b)) ? a : b};
      default: return {1'b1, 32'd0};
    endcase
  endfunction

  // Single issue, waits until the buffer has room
  task automatic issue_insn(fu_op_e op, logic [2:0] func, logic [31:0] a, logic [31:0] b,
                            output logic [TRANS_ID_BITS-1:0] id);
    logic [31:0] word;
    word = rand_bits(32);
    word[14:12] = func;
    @(negedge clk_i);
    while (!acc_ready_o) @(negedge clk_i);
    id = next_id;
    @(posedge clk_i);
    acc_valid_i <= 1'b1;
    acc_data_i  <= '{operator: op, operand_a: a, operand_b: b, imm: word, trans_id: id};
    @(posedge clk_i);
    acc_valid_i <= 1'b0;
    next_id = next_id + 1'b1;
  endtask

  // Commit after a random delay and record the expected response
  task automatic commit_insn(logic [TRANS_ID_BITS-1:0] id, fu_op_e op, logic [2:0] func,
                             logic [31:0] a, logic [31:0] b);
    logic [32:0] exp;
    exp = ref_exec(func, a, b);
    repeat (rand_bits(2)) @(posedge clk_i);
    checker_inst.add_expected(id, exp[31:0], exp[32], op);
    @(posedge clk_i);
    acc_commit_i          <= 1'b1;
    acc_commit_trans_id_i <= id;
    @(posedge clk_i);
    acc_commit_i <= 1'b0;
  endtask

  // Wait for all expected results, bounded
  task automatic wait_drained();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (checker_inst.pending() != 0 && cycles < 40) begin
      @(negedge clk_i);
      cycles++;
    end
    if (checker_inst.pending() != 0) begin
      checker_inst.note_error("result never arrived after commit");
    end
  endtask

  task automatic run_insn(fu_op_e op, logic [2:0] func);
    logic [31:0]              a;
    logic [31:0]              b;
    logic [TRANS_ID_BITS-1:0] id;
    a = rand_bits(32);
    b = rand_bits(32);
    issue_insn(op, func, a, b, id);
    commit_insn(id, op, func, a, b);
    wait_drained();
  endtask

  // Results seen must not move during a quiet window
  task automatic expect_quiet(int unsigned cycles, string what);
    seen_before = checker_inst.results_seen;
    repeat (cycles) @(negedge clk_i);
    if (checker_inst.results_seen != seen_before) begin
      checker_inst.note_error(what);
    end
  endtask

  initial begin
    logic [TRANS_ID_BITS-1:0] id_a;
    logic [TRANS_ID_BITS-1:0] id_b;
    logic [31:0]              a;
    logic [31:0]              b;
    clk_i                 = 1'b0;
    rst_i                 = 1'b1;
    flush_i               = 1'b0;
    acc_data_i            = '0;
    acc_valid_i           = 1'b0;
    acc_commit_i          = 1'b0;
    acc_commit_trans_id_i = '0;
    acc_no_st_pending_i   = 1'b1;
    next_id               = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    checker_inst.start_test();
    for (int f = 0; f < 5; f++) begin
      repeat (4) run_insn(ACC_OP_ARITH, 3'(f));
    end
    checker_inst.end_test("legal functions");

    checker_inst.start_test();
    for (int f = 5; f < 8; f++) run_insn(ACC_OP_ARITH, 3'(f));
    checker_inst.end_test("illegal codes");

    // Held until commit
    checker_inst.start_test();
    a = rand_bits(32);
    b = rand_bits(32);
    issue_insn(ACC_OP_ARITH, 3'd0, a, b, id_a);
    expect_quiet(12, "result appeared before commit");
    commit_insn(id_a, ACC_OP_ARITH, 3'd0, a, b);
    wait_drained();
    checker_inst.end_test("commit gating");

    // Store pending stalls dispatch
    checker_inst.start_test();
    @(posedge clk_i);
    acc_no_st_pending_i <= 1'b0;
    a = rand_bits(32);
    b = rand_bits(32);
    issue_insn(ACC_OP_ARITH, 3'd2, a, b, id_a);
    issue_insn(ACC_OP_ARITH, 3'd1, b, a, id_b);
    // Head and spare both held, so no room for a third
    @(negedge clk_i);
    if (acc_ready_o !== 1'b0) begin
      checker_inst.mismatch("issue ready high with both buffer entries held");
    end
    commit_insn(id_a, ACC_OP_ARITH, 3'd2, a, b);
    expect_quiet(10, "result appeared while a store was pending");
    @(posedge clk_i);
    acc_no_st_pending_i <= 1'b1;
    wait_drained();
    commit_insn(id_b, ACC_OP_ARITH, 3'd1, b, a);
    wait_drained();
    checker_inst.end_test("store stall");

    checker_inst.start_test();
    run_insn(ACC_OP_ARITH, 3'd0);
    run_insn(ACC_OP_LOAD, 3'd3);
    run_insn(ACC_OP_STORE, 3'd4);
    checker_inst.end_test("dispatch flags");

    // Flush drops the uncommitted head
    checker_inst.start_test();
    issue_insn(ACC_OP_ARITH, 3'd0, rand_bits(32), rand_bits(32), id_a);
    repeat (3) @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    expect_quiet(10, "flushed instruction produced a result");
    run_insn(ACC_OP_ARITH, 3'd3);
    checker_inst.end_test("flush");

    checker_inst.print_summary();
    if (checker_inst.error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (NUM_INSNS * 40 + 1000) @(posedge clk_i);
    $display("Watchdog expired, the run timed out");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== acc_offload.f ====
logic/core_if_pkg.sv
logic/acc_if_pkg.sv
logic/acc_issue_buffer.sv
logic/acc_dispatcher.sv
logic/acc_unit.sv
logic/acc_offload_top.sv
bench/acc_offload_checker.sv
bench/acc_offload_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= acc_offload_tb
FILELIST  ?= acc_offload.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
